// ==== source/eth_tx_pkg.sv ====
`default_nettype none

package eth_tx_pkg;

	////////////////////////////////////////
	// Register map of one queue window

	// Status, read only
	localparam logic [7:0] REG_STAT   = 8'h00;
	// Any write closes the frame in progress
	localparam logic [7:0] REG_COMMIT = 8'h20;
	// Declared frame length in bytes
	localparam logic [7:0] REG_LENGTH = 8'h40;
	// Frame data, every offset from here up
	localparam logic [7:0] REG_TX_BUF = 8'h80;

	////////////////////////////////////////
	// Widths

	// Frame length field and byte counters
	localparam int LEN_W  = 11;
	// Queue index, taken from paddr[9:8]
	localparam int QIDX_W = 2;

	////////////////////////////////////////
	// APB write word

	// Same 32 bits seen as frame bytes or as the length register
	typedef union packed {
		logic [3:0][7:0] bytes;
		struct packed {
			logic [31-LEN_W:0] rsvd;
			logic [LEN_W-1:0]  frame_len;
		} len_reg;
	} apb_wdata_u;

endpackage

`default_nettype wire

// ==== source/apb_tx_frontend.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_tx_frontend #(
	parameter int NUM_QUEUES = 4,
	parameter int ADDR_W     = 10
) (
	input wire                     apb,
	input wire                     rst_n,
	input wire                     psel,
	input wire                     penable,
	input wire                     pwrite,
	input wire [ADDR_W-1:0]        paddr,
	input wire [31:0]              pwdata,
	input wire [3:0]               pstrb,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	input wire [NUM_QUEUES-1:0]    busy,
	input wire                     link_up,
	input wire [NUM_QUEUES-1:0]    frames_pending,
	output logic [NUM_QUEUES-1:0]  buf_wr,
	output logic [NUM_QUEUES-1:0]  len_wr,
	output logic [NUM_QUEUES-1:0]  commit,
	output eth_tx_pkg::apb_wdata_u wdata,
	output logic [3:0]             strb
);

	localparam int                  QW    = eth_tx_pkg::QIDX_W;
	localparam logic [NUM_QUEUES-1:0] Q_ONE = NUM_QUEUES'(1);

	logic [QW-1:0]         q_idx;
	logic [7:0]            offset;
	logic                  in_range;
	logic                  q_busy;
	logic [NUM_QUEUES-1:0] q_sel;
	logic                  wr_done;

	////////////////////////////////////////
	// Address decode

	always_comb begin
		// Top address bits pick the queue, low byte picks the register
		q_idx    = paddr[ADDR_W-1 -: QW];
		offset   = paddr[7:0];
		in_range = int'(q_idx) < NUM_QUEUES;
		// Out of range queues never stall
		q_busy   = in_range && busy[q_idx];
		q_sel    = Q_ONE << q_idx;
	end

	// Only writes to a busy queue get wait states
	assign pready  = psel && penable && !(pwrite && q_busy);
	assign wr_done = pready && pwrite && in_range;

	////////////////////////////////////////
	// Read data and error response

	always_comb begin
		prdata  = '0;
		pslverr = 1'b0;
		if (pready) begin
			if (pwrite) begin
				// Status is read only
				if (!in_range || offset == eth_tx_pkg::REG_STAT)
					pslverr = 1'b1;
			end
			else if (in_range && offset == eth_tx_pkg::REG_STAT) begin
				// Bit 0 link state, bit 1 frame waiting in this queue
				prdata = {30'h0, frames_pending[q_idx], link_up};
			end
			else begin
				// Buffer and control registers are write only
				pslverr = 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Per-queue write strobes

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			buf_wr <= '0;
			len_wr <= '0;
			commit <= '0;
		end
		else begin
			// Single cycle pulses by default
			buf_wr <= '0;
			len_wr <= '0;
			commit <= '0;

			// Writes still complete with link down but have no effect
			if (wr_done && link_up) begin
				if (offset >= eth_tx_pkg::REG_TX_BUF)
					buf_wr <= q_sel;
				else if (offset == eth_tx_pkg::REG_LENGTH)
					len_wr <= q_sel;
				else if (offset == eth_tx_pkg::REG_COMMIT)
					commit <= q_sel;
			end
		end
	end

	// Write word and strobes ride along with the pulses
	always_ff @(posedge apb) begin
		if (wr_done) begin
			wdata <= pwdata;
			strb  <= pstrb;
		end
	end

endmodule

`default_nettype wire

// ==== source/tx_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module tx_queue #(
	parameter int FIFO_DEPTH = 64,
	parameter int LEN_DEPTH  = 4
) (
	input wire                            apb,
	input wire                            rst_n,
	input wire                            link_up,
	input wire                            buf_wr,
	input wire                            len_wr,
	input wire                            commit,
	input wire eth_tx_pkg::apb_wdata_u    wdata,
	input wire [3:0]                      strb,
	input wire                            pop_len,
	input wire                            pop_byte,
	output logic                          busy,
	output logic                          frame_avail,
	output logic [eth_tx_pkg::LEN_W-1:0]  frame_len,
	output logic [7:0]                    byte_data
);

	localparam int LW     = eth_tx_pkg::LEN_W;
	localparam int PTR_W  = $clog2(FIFO_DEPTH);
	localparam int LPTR_W = $clog2(LEN_DEPTH);

	// Serializer state
	logic [LW-1:0]   decl_len;
	logic [LW-1:0]   byte_cnt;
	logic [2:0][7:0] pend_bytes;
	logic [1:0]      pend_cnt;
	logic            lane_valid;
	logic            lane_step;
	logic [7:0]      lane_data;

	// Byte FIFO
	logic [7:0]   byte_mem [FIFO_DEPTH];
	logic [PTR_W:0] byte_wr_ptr;
	logic [PTR_W:0] byte_rd_ptr;
	logic [PTR_W:0] byte_level;
	logic         byte_full;
	logic         byte_afull;
	logic         byte_empty;
	logic         byte_push;
	logic         byte_pop;

	// Length FIFO
	logic [LW-1:0]   len_mem [LEN_DEPTH];
	logic [LPTR_W:0] len_wr_ptr;
	logic [LPTR_W:0] len_rd_ptr;
	logic [LPTR_W:0] len_level;
	logic            len_full;
	logic            len_empty;
	logic            len_push;
	logic            len_pop;

	////////////////////////////////////////
	// Flags and datapath control

	always_comb begin
		byte_level = byte_wr_ptr - byte_rd_ptr;
		byte_full  = byte_level == (PTR_W+1)'(FIFO_DEPTH);
		byte_afull = byte_level >= (PTR_W+1)'(FIFO_DEPTH - 1);
		byte_empty = byte_level == '0;
		len_level  = len_wr_ptr - len_rd_ptr;
		len_full   = len_level == (LPTR_W+1)'(LEN_DEPTH);
		len_empty  = len_level == '0;

		// Byte 0 goes straight in, the rest drain from pend_bytes
		lane_step  = !buf_wr && pend_cnt != 2'd0 && !byte_full;
		lane_valid = buf_wr ? strb[0] : lane_step;
		lane_data  = buf_wr ? wdata.bytes[0] : pend_bytes[0];

		// Bytes past the declared length are consumed but not stored
		byte_push = lane_valid && byte_cnt < decl_len && !byte_full;
		byte_pop  = pop_byte && !byte_empty;
		// Empty frames never reach the length FIFO
		len_push  = commit && byte_cnt != '0 && !len_full;
		len_pop   = pop_len && !len_empty;
	end

	// Stall the APB side while serializing or close to full
	assign busy        = buf_wr || pend_cnt != 2'd0 || byte_afull || len_full;
	assign frame_avail = !len_empty;
	assign frame_len   = len_mem[len_rd_ptr[LPTR_W-1:0]];
	assign byte_data   = byte_mem[byte_rd_ptr[PTR_W-1:0]];

	////////////////////////////////////////
	// Pointers and counters

	// Link down flushes the queue just like reset
	always_ff @(posedge apb) begin
		if (!rst_n || !link_up) begin
			byte_wr_ptr <= '0;
			byte_rd_ptr <= '0;
			len_wr_ptr  <= '0;
			len_rd_ptr  <= '0;
			byte_cnt    <= '0;
			decl_len    <= '0;
			pend_cnt    <= 2'd0;
		end
		else begin
			if (byte_push)
				byte_wr_ptr <= byte_wr_ptr + 1'b1;
			if (byte_pop)
				byte_rd_ptr <= byte_rd_ptr + 1'b1;
			if (len_push)
				len_wr_ptr <= len_wr_ptr + 1'b1;
			if (len_pop)
				len_rd_ptr <= len_rd_ptr + 1'b1;
			if (byte_push)
				byte_cnt <= byte_cnt + 1'b1;

			// Count of strobed bytes still waiting behind byte 0
			if (buf_wr)
				pend_cnt <= strb[3] ? 2'd3 : strb[2] ? 2'd2 : strb[1] ? 2'd1 : 2'd0;
			else if (lane_step)
				pend_cnt <= pend_cnt - 1'b1;

			if (len_wr)
				decl_len <= wdata.len_reg.frame_len;

			// New frame starts from scratch
			if (commit) begin
				byte_cnt <= '0;
				decl_len <= '0;
			end
		end
	end

	////////////////////////////////////////
	// Storage

	always_ff @(posedge apb) begin
		if (byte_push)
			byte_mem[byte_wr_ptr[PTR_W-1:0]] <= lane_data;
		if (len_push)
			len_mem[len_wr_ptr[LPTR_W-1:0]] <= byte_cnt;
		if (buf_wr)
			pend_bytes <= wdata.bytes[3:1];
		else if (lane_step)
			pend_bytes <= {8'h00, pend_bytes[2:1]};
	end

	////////////////////////////////////////
	// Checks

	// pready wait states must keep room for the first byte
	a_byte_no_overflow: assert property (@(posedge apb) disable iff (!rst_n || !link_up)
		(buf_wr && strb[0] && byte_cnt < decl_len) |-> !byte_full);

	a_len_no_overflow: assert property (@(posedge apb) disable iff (!rst_n || !link_up)
		(commit && byte_cnt != '0) |-> !len_full);

	// Scheduler only pops what it was told is there
	a_byte_no_underflow: assert property (@(posedge apb) disable iff (!rst_n || !link_up)
		pop_byte |-> !byte_empty);

	a_len_no_underflow: assert property (@(posedge apb) disable iff (!rst_n || !link_up)
		pop_len |-> !len_empty);

	a_strb_contiguous: assert property (@(posedge apb) disable iff (!rst_n)
		buf_wr |-> strb inside {4'b0001, 4'b0011, 4'b0111, 4'b1111});

endmodule

`default_nettype wire

// ==== source/tx_scheduler.sv ====
`timescale 1ns/1ns
`default_nettype none

module tx_scheduler #(
	parameter int NUM_QUEUES = 4
) (
	input wire                                          apb,
	input wire                                          rst_n,
	input wire                                          tx_ready,
	input wire [NUM_QUEUES-1:0]                         frame_avail,
	input wire [NUM_QUEUES-1:0][eth_tx_pkg::LEN_W-1:0]  frame_len,
	input wire [NUM_QUEUES-1:0][7:0]                    byte_data,
	output logic [NUM_QUEUES-1:0]                       pop_len,
	output logic [NUM_QUEUES-1:0]                       pop_byte,
	output logic                                        tx_valid,
	output logic                                        tx_start,
	output logic                                        tx_last,
	output logic [7:0]                                  tx_data,
	output logic [eth_tx_pkg::QIDX_W-1:0]               tx_queue
);

	localparam int                    QW    = eth_tx_pkg::QIDX_W;
	localparam int                    LW    = eth_tx_pkg::LEN_W;
	localparam logic [NUM_QUEUES-1:0] Q_ONE = NUM_QUEUES'(1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_POP,
		ST_SEND
	} state_t;

	state_t        state;
	logic [QW-1:0] rr_ptr;
	logic [QW-1:0] pick;
	logic          found;
	logic          go;
	logic          popping;
	logic [LW-1:0] remain;

	////////////////////////////////////////
	// Round-robin pick

	// First queue with a frame, searching upward from rr_ptr
	always_comb begin : pick_logic
		int idx;
		found = 1'b0;
		pick  = '0;
		for (int k = 0; k < NUM_QUEUES; k++) begin
			idx = (int'(rr_ptr) + k) % NUM_QUEUES;
			if (!found && frame_avail[idx]) begin
				found = 1'b1;
				pick  = QW'(idx);
			end
		end
	end

	assign go      = state == ST_IDLE && tx_ready && found;
	// Pop state takes the first byte, send takes the rest
	assign popping = state == ST_POP || (state == ST_SEND && remain != '0);

	assign pop_len  = go ? Q_ONE << pick : '0;
	assign pop_byte = popping ? Q_ONE << tx_queue : '0;

	////////////////////////////////////////
	// FSM and output stream

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			rr_ptr   <= '0;
			remain   <= '0;
			tx_queue <= '0;
			tx_valid <= 1'b0;
			tx_start <= 1'b0;
			tx_last  <= 1'b0;
		end
		else begin
			// Output flags lag the pops by one cycle, like tx_data
			tx_valid <= popping;
			tx_start <= state == ST_POP;
			tx_last  <= popping && remain == LW'(1);

			if (popping)
				remain <= remain - 1'b1;

			case (state)
				ST_IDLE: begin
					if (go) begin
						state    <= ST_POP;
						tx_queue <= pick;
						remain   <= frame_len[pick];
						// Next search begins after the served queue
						rr_ptr   <= (int'(pick) == NUM_QUEUES - 1) ? '0 : pick + 1'b1;
					end
				end
				ST_POP:
					state <= ST_SEND;
				ST_SEND: begin
					// Tail cycle shows the last byte, then back to idle
					if (tx_last)
						state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge apb) begin
		if (popping)
			tx_data <= byte_data[tx_queue];
	end

	////////////////////////////////////////
	// Checks

	a_start_valid: assert property (@(posedge apb) disable iff (!rst_n)
		tx_start |-> tx_valid);

	// No gaps inside a frame
	a_valid_contiguous: assert property (@(posedge apb) disable iff (!rst_n)
		(tx_valid && !tx_last) |=> tx_valid);

endmodule

`default_nettype wire

// ==== source/eth_tx_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module eth_tx_top #(
	parameter int NUM_QUEUES = 4,
	parameter int FIFO_DEPTH = 64,
	parameter int LEN_DEPTH  = 4,
	parameter int ADDR_W     = 10
) (
	input wire                            apb,
	input wire                            rst_n,
	input wire                            psel,
	input wire                            penable,
	input wire                            pwrite,
	input wire [ADDR_W-1:0]               paddr,
	input wire [31:0]                     pwdata,
	input wire [3:0]                      pstrb,
	output logic [31:0]                   prdata,
	output logic                          pready,
	output logic                          pslverr,
	input wire                            link_up,
	input wire                            tx_ready,
	output logic                          tx_valid,
	output logic                          tx_start,
	output logic                          tx_last,
	output logic [7:0]                    tx_data,
	output logic [eth_tx_pkg::QIDX_W-1:0] tx_queue
);

	// Front end to queues
	logic [NUM_QUEUES-1:0]  buf_wr;
	logic [NUM_QUEUES-1:0]  len_wr;
	logic [NUM_QUEUES-1:0]  commit;
	logic [NUM_QUEUES-1:0]  busy;
	eth_tx_pkg::apb_wdata_u wdata;
	logic [3:0]             strb;

	// Queues to scheduler
	logic [NUM_QUEUES-1:0]                        frame_avail;
	logic [NUM_QUEUES-1:0][eth_tx_pkg::LEN_W-1:0] frame_len;
	logic [NUM_QUEUES-1:0][7:0]                   byte_data;
	logic [NUM_QUEUES-1:0]                        pop_len;
	logic [NUM_QUEUES-1:0]                        pop_byte;

	apb_tx_frontend #(
		.NUM_QUEUES(NUM_QUEUES),
		.ADDR_W(ADDR_W)
	) u_frontend (
		.apb(apb),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.busy(busy),
		.link_up(link_up),
		.frames_pending(frame_avail),
		.buf_wr(buf_wr),
		.len_wr(len_wr),
		.commit(commit),
		.wdata(wdata),
		.strb(strb)
	);

	// One byte queue per APB window
	for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_queue
		tx_queue #(
			.FIFO_DEPTH(FIFO_DEPTH),
			.LEN_DEPTH(LEN_DEPTH)
		) u_queue (
			.apb(apb),
			.rst_n(rst_n),
			.link_up(link_up),
			.buf_wr(buf_wr[i]),
			.len_wr(len_wr[i]),
			.commit(commit[i]),
			.wdata(wdata),
			.strb(strb),
			.pop_len(pop_len[i]),
			.pop_byte(pop_byte[i]),
			.busy(busy[i]),
			.frame_avail(frame_avail[i]),
			.frame_len(frame_len[i]),
			.byte_data(byte_data[i])
		);
	end

	tx_scheduler #(
		.NUM_QUEUES(NUM_QUEUES)
	) u_scheduler (
		.apb(apb),
		.rst_n(rst_n),
		.tx_ready(tx_ready),
		.frame_avail(frame_avail),
		.frame_len(frame_len),
		.byte_data(byte_data),
		.pop_len(pop_len),
		.pop_byte(pop_byte),
		.tx_valid(tx_valid),
		.tx_start(tx_start),
		.tx_last(tx_last),
		.tx_data(tx_data),
		.tx_queue(tx_queue)
	);

endmodule

`default_nettype wire

// ==== verif/tb_eth_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_eth_tx;

	localparam int          NQ         = 4;
	localparam int          WAIT_LIMIT = 1000;
	localparam logic [31:0] SEED       = 32'h5ced_ff72;

	typedef logic [7:0]  byte_list_t[$];
	typedef logic [31:0] word_list_t[$];
	typedef logic [3:0]  strb_list_t[$];

	logic        apb;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [9:0]  paddr;
	logic [31:0] pwdata;
	logic [3:0]  pstrb;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        link_up;
	logic        tx_ready;
	logic        tx_valid;
	logic        tx_start;
	logic        tx_last;
	logic [7:0]  tx_data;
	logic [1:0]  tx_queue;

	// Expected frames kept as one list per DUT queue
	int         exp_lens[NQ][$];
	logic [7:0] exp_bytes[NQ][$];
	// Queue index of every frame seen in order
	int         order_log[$];
	logic [7:0] rx_bytes[$];
	logic       in_frame = 1'b0;
	int         cur_q    = 0;
	int         checks   = 0;
	int         errors   = 0;
	int         timeouts = 0;

	eth_tx_top #(
		.NUM_QUEUES(NQ),
		.FIFO_DEPTH(64),
		.LEN_DEPTH(4),
		.ADDR_W(10)
	) u_eth_tx_top (
		.apb(apb),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pstrb(pstrb),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.link_up(link_up),
		.tx_ready(tx_ready),
		.tx_valid(tx_valid),
		.tx_start(tx_start),
		.tx_last(tx_last),
		.tx_data(tx_data),
		.tx_queue(tx_queue)
	);

	// 4 ns clock
	initial begin
		apb = 1'b0;
		forever #2 apb = ~apb;
	end

	////////////////////////////////////////
	// Checking helpers

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
		end
	endtask

	// Strobed bytes in lane order up to the declared length
	function automatic byte_list_t expected_bytes(input int decl_len, input word_list_t words,
		input strb_list_t strobes);
		byte_list_t res;
		for (int w = 0; w < words.size(); w++) begin
			for (int b = 0; b < 4; b++) begin
				if (strobes[w][b] && res.size() < decl_len)
					res.push_back(words[w][8*b +: 8]);
			end
		end
		return res;
	endfunction

	function automatic int frames_pending();
		int n;
		n = 0;
		for (int q = 0; q < NQ; q++)
			n += exp_lens[q].size();
		return n;
	endfunction

	function automatic logic [9:0] queue_addr(input int q, input logic [7:0] offset);
		return {q[1:0], offset};
	endfunction

	////////////////////////////////////////
	// APB master

	// Starts and ends 1 ns after a rising edge and samples at the falling edge
	task automatic apb_transfer(input logic wr, input logic [9:0] addr, input logic [31:0] data,
		input logic [3:0] strobe, output logic [31:0] rdata, output logic err);
		int waits;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		pstrb   = strobe;
		@(posedge apb);
		#1;
		penable = 1'b1;
		waits   = 0;
		@(negedge apb);
		// Busy queues stretch the access phase
		while (!pready && waits < WAIT_LIMIT) begin
			@(negedge apb);
			waits++;
		end
		if (!pready) begin
			timeouts++;
			$display("ERROR: no pready after %0d cycles on %s at 0x%03h",
				waits, wr ? "write" : "read", addr);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge apb);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [9:0] addr, input logic [31:0] data,
		input logic [3:0] strobe, output logic err);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, strobe, unused, err);
	endtask

	task automatic apb_read(input logic [9:0] addr, output logic [31:0] data,
		output logic err);
		apb_transfer(1'b0, addr, 32'h0, 4'h0, data, err);
	endtask

	// Writes the length and the data words and then commits
	task automatic send_frame(input int q, input int decl_len, input word_list_t words,
		input strb_list_t strobes);
		byte_list_t exp;
		logic       err;
		apb_write(queue_addr(q, eth_tx_pkg::REG_LENGTH), decl_len, 4'hf, err);
		check_value(err, 1'b0, "pslverr on length write");
		for (int i = 0; i < words.size(); i++) begin
			apb_write(queue_addr(q, eth_tx_pkg::REG_TX_BUF + 8'(4 * i)), words[i],
				strobes[i], err);
			check_value(err, 1'b0, "pslverr on buffer write");
		end
		// Model holds the frame before the commit lands
		exp = expected_bytes(decl_len, words, strobes);
		// Empty frames never leave the queue
		if (exp.size() > 0) begin
			exp_lens[q].push_back(exp.size());
			foreach (exp[i])
				exp_bytes[q].push_back(exp[i]);
		end
		apb_write(queue_addr(q, eth_tx_pkg::REG_COMMIT), 32'h0, 4'hf, err);
		check_value(err, 1'b0, "pslverr on commit write");
		// Length FIFO entry appears one cycle after the commit
		@(posedge apb);
		#1;
	endtask

	task automatic wait_drained(input int limit, input string what);
		int cycles;
		cycles = 0;
		while ((frames_pending() != 0 || in_frame) && cycles < limit) begin
			@(posedge apb);
			cycles++;
		end
		if (frames_pending() != 0 || in_frame) begin
			timeouts++;
			$display("ERROR: %s, %0d frames still not sent after %0d cycles",
				what, frames_pending(), cycles);
		end
		@(posedge apb);
		#1;
	endtask

	////////////////////////////////////////
	// Output monitor and comparator

	task automatic compare_frame(input int q);
		int         exp_len;
		logic [7:0] exp_byte;
		if (exp_lens[q].size() == 0) begin
			errors++;
			$display("ERROR: unexpected frame of %0d bytes from queue %0d at %0t ns",
				rx_bytes.size(), q, $time);
		end
		else begin
			exp_len = exp_lens[q].pop_front();
			check_value(rx_bytes.size(), exp_len, $sformatf("queue %0d frame length", q));
			for (int i = 0; i < exp_len; i++) begin
				exp_byte = exp_bytes[q].pop_front();
				if (i < rx_bytes.size())
					check_value(rx_bytes[i], exp_byte, $sformatf("queue %0d byte %0d", q, i));
			end
		end
	endtask

	// Stream outputs are registered so the falling edge sees them settled
	always @(negedge apb) begin
		if (rst_n) begin
			if (tx_valid) begin
				if (tx_start) begin
					if (in_frame) begin
						errors++;
						$display("ERROR: tx_start inside a frame at %0t ns", $time);
					end
					in_frame = 1'b1;
					cur_q    = int'(tx_queue);
					rx_bytes.delete();
					order_log.push_back(cur_q);
				end
				else if (!in_frame) begin
					errors++;
					$display("ERROR: tx_valid without tx_start at %0t ns", $time);
				end
				if (in_frame)
					rx_bytes.push_back(tx_data);
				if (tx_last && in_frame) begin
					compare_frame(cur_q);
					in_frame = 1'b0;
				end
			end
			else if (in_frame) begin
				errors++;
				$display("ERROR: tx_valid dropped inside a frame at %0t ns", $time);
				in_frame = 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// Scenarios

	initial begin : main
		word_list_t  words;
		strb_list_t  strobes;
		logic [31:0] rdata;
		logic        err;
		int          q;
		int          len;
		int          nwords;
		int          lanes;

		rst_n    = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		pstrb    = '0;
		link_up  = 1'b1;
		tx_ready = 1'b1;
		void'($urandom(SEED));
		repeat (2) @(posedge apb);
		#1;
		rst_n = 1'b1;

		// Twelve bytes of full words on queue 0
		words   = '{32'h03020100, 32'h07060504, 32'h0b0a0908};
		strobes = '{4'hf, 4'hf, 4'hf};
		send_frame(0, 12, words, strobes);
		wait_drained(WAIT_LIMIT, "whole word frame");

		// Partial strobes and truncation on queue 3 which leaves the pointer at 0
		words   = '{32'ha3a2a1a0, 32'hb3b2b1b0, 32'hc3c2c1c0, 32'hd3d2d1d0, 32'he3e2e1e0};
		strobes = '{4'h1, 4'h3, 4'h7, 4'hf, 4'hf};
		send_frame(3, 10, words, strobes);
		words   = '{32'h44332211, 32'h88776655};
		strobes = '{4'h7, 4'h7};
		send_frame(3, 20, words, strobes);
		wait_drained(WAIT_LIMIT, "truncation frames");

		// Round robin held back until all three are committed
		tx_ready = 1'b0;
		order_log.delete();
		words   = '{32'h22222222};
		strobes = '{4'hf};
		send_frame(2, 4, words, strobes);
		words   = '{32'h00000000, 32'h01010101};
		strobes = '{4'hf, 4'h3};
		send_frame(0, 6, words, strobes);
		words   = '{32'h33333333};
		strobes = '{4'h3};
		send_frame(3, 2, words, strobes);
		tx_ready = 1'b1;
		wait_drained(WAIT_LIMIT, "round robin first pass");
		check_value(order_log.size(), 3, "frames in first round");
		if (order_log.size() == 3) begin
			check_value(order_log[0], 0, "first round, first queue");
			check_value(order_log[1], 2, "first round, second queue");
			check_value(order_log[2], 3, "first round, third queue");
		end
		// Last served was queue 3 so queue 0 wins next
		tx_ready = 1'b0;
		order_log.delete();
		words   = '{32'h3c3c3c3c};
		strobes = '{4'hf};
		send_frame(3, 4, words, strobes);
		words   = '{32'h0c0c0c0c};
		strobes = '{4'h1};
		send_frame(0, 4, words, strobes);
		tx_ready = 1'b1;
		wait_drained(WAIT_LIMIT, "round robin second pass");
		check_value(order_log.size(), 2, "frames in second round");
		if (order_log.size() == 2) begin
			check_value(order_log[0], 0, "second round, first queue");
			check_value(order_log[1], 3, "second round, second queue");
		end

		// Register access errors
		apb_write(queue_addr(0, eth_tx_pkg::REG_STAT), 32'h0, 4'hf, err);
		check_value(err, 1'b1, "pslverr on status write");
		apb_read(queue_addr(0, eth_tx_pkg::REG_LENGTH), rdata, err);
		check_value(err, 1'b1, "pslverr on length read");
		apb_read(queue_addr(1, eth_tx_pkg::REG_TX_BUF), rdata, err);
		check_value(err, 1'b1, "pslverr on buffer read");
		// With four queues every index decodes
		if (NQ < 4) begin
			apb_write(queue_addr(NQ, eth_tx_pkg::REG_TX_BUF), 32'h0, 4'hf, err);
			check_value(err, 1'b1, "pslverr on out of range write");
			apb_read(queue_addr(NQ, eth_tx_pkg::REG_STAT), rdata, err);
			check_value(err, 1'b1, "pslverr on out of range read");
		end

		// Status has frame waiting in bit 1 and link up in bit 0
		tx_ready = 1'b0;
		words   = '{32'h11111111, 32'h12121212};
		strobes = '{4'hf, 4'hf};
		send_frame(1, 8, words, strobes);
		apb_read(queue_addr(1, eth_tx_pkg::REG_STAT), rdata, err);
		check_value(err, 1'b0, "pslverr on status read");
		check_value(rdata, 32'h3, "status of queue with a frame");
		apb_read(queue_addr(2, eth_tx_pkg::REG_STAT), rdata, err);
		check_value(rdata, 32'h1, "status of empty queue");
		tx_ready = 1'b1;
		wait_drained(WAIT_LIMIT, "status frame");

		// Zero declared length followed by a bare commit
		words   = '{32'hdeadbeef};
		strobes = '{4'hf};
		send_frame(2, 0, words, strobes);
		apb_write(queue_addr(2, eth_tx_pkg::REG_COMMIT), 32'h0, 4'hf, err);
		apb_read(queue_addr(2, eth_tx_pkg::REG_STAT), rdata, err);
		check_value(rdata, 32'h1, "status after zero length commits");

		// Link down flushes everything queued
		tx_ready = 1'b0;
		words   = '{32'h5a5a5a5a};
		strobes = '{4'hf};
		send_frame(1, 4, words, strobes);
		send_frame(2, 4, words, strobes);
		link_up = 1'b0;
		apb_write(queue_addr(1, eth_tx_pkg::REG_LENGTH), 32'h8, 4'hf, err);
		check_value(err, 1'b0, "pslverr on length write with link down");
		apb_write(queue_addr(1, eth_tx_pkg::REG_TX_BUF), 32'h9999, 4'hf, err);
		check_value(err, 1'b0, "pslverr on buffer write with link down");
		link_up = 1'b1;
		for (int i = 0; i < NQ; i++) begin
			exp_lens[i].delete();
			exp_bytes[i].delete();
		end
		apb_read(queue_addr(1, eth_tx_pkg::REG_STAT), rdata, err);
		check_value(rdata, 32'h1, "queue 1 status after flush");
		apb_read(queue_addr(2, eth_tx_pkg::REG_STAT), rdata, err);
		check_value(rdata, 32'h1, "queue 2 status after flush");
		// Only the new frame may come out
		order_log.delete();
		tx_ready = 1'b1;
		words   = '{32'h76543210};
		strobes = '{4'hf};
		send_frame(1, 4, words, strobes);
		wait_drained(WAIT_LIMIT, "frame after link up");
		check_value(order_log.size(), 1, "frames after link down");

		// Random frames with some written past their length
		for (int f = 0; f < 20; f++) begin
			q      = $urandom % NQ;
			len    = 1 + $urandom % 60;
			nwords = 1 + $urandom % 16;
			words.delete();
			strobes.delete();
			for (int i = 0; i < nwords; i++) begin
				lanes = 1 + $urandom % 4;
				words.push_back($urandom);
				strobes.push_back(4'((1 << lanes) - 1));
			end
			send_frame(q, len, words, strobes);
		end
		wait_drained(5000, "random traffic");

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
source/eth_tx_pkg.sv
source/apb_tx_frontend.sv
source/tx_queue.sv
source/tx_scheduler.sv
source/eth_tx_top.sv
verif/tb_eth_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f src.f \
	--top-module tb_eth_tx -o sim_eth_tx > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/sim_eth_tx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
	exit 0
fi
exit 1
